// File: source/dram_pkg.sv
package dram_pkg;

    // DRAM write port
    localparam int DRAM_DATA_W = 288;  // one DRAM word without byte enables
    localparam int DRAM_ADDR_W = 25;   // word address whose top bit picks the channel half

    // word numbering inside one channel's half of the address space
    localparam int WORD_IDX_W = 24;

    // beat widths of the two sample streams
    localparam int CH_A_W = 32;  // 9 beats per DRAM word
    localparam int CH_B_W = 16;  // 18 beats per DRAM word

    // value of the top address bit for each channel
    localparam logic CH_A_SEL = 1'b0;
    localparam logic CH_B_SEL = 1'b1;

endpackage

// File: source/dram_word_if.sv
interface dram_word_if (
    input logic clk
);

    logic                             word_valid;  // one cycle per finished word
    logic [dram_pkg::DRAM_DATA_W-1:0] word_data;   // first beat in the low bits
    logic [dram_pkg::WORD_IDX_W-1:0]  word_idx;    // running word number of the channel

    // packer side
    modport producer (
        input  clk,
        output word_valid,
        output word_data,
        output word_idx
    );

    // arbiter side that samples data and index only while word_valid is high
    modport consumer (
        input  clk,
        input  word_valid,
        input  word_data,
        input  word_idx
    );

endinterface

// File: source/sample_packer.sv
module sample_packer #(
    parameter int DIN_W = 32  // must divide the DRAM word width
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [DIN_W-1:0] din,
    input  logic             din_valid,
    dram_word_if.producer    word
);

    localparam int BEATS = dram_pkg::DRAM_DATA_W / DIN_W;
    localparam int CNT_W = $clog2(BEATS);
    localparam int BUF_W = dram_pkg::DRAM_DATA_W - DIN_W;  // everything but the last beat

    logic [CNT_W-1:0]                beat_cnt;   // slice the next beat goes to
    logic [BUF_W-1:0]                part_buf;   // partial word, low slices first
    logic [dram_pkg::WORD_IDX_W-1:0] idx_cnt;    // number of the word being built
    logic                            last_beat;  // accepted beat finishes the word

    assign last_beat = din_valid && (beat_cnt == CNT_W'(BEATS - 1));

    // beat and word counters
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt        <= '0;
            idx_cnt         <= '0;  // first word after reset is word 0
            word.word_valid <= 1'b0;
        end else begin
            word.word_valid <= last_beat;  // pulse one cycle after the closing beat
            if (last_beat) begin
                beat_cnt <= '0;
                idx_cnt  <= idx_cnt + 1'b1;  // wraps after the full index range
            end else if (din_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // partial word fills from the low slice up
    always_ff @(posedge clk) begin
        if (din_valid && !last_beat) begin
            part_buf[beat_cnt*DIN_W +: DIN_W] <= din;
        end
        if (last_beat) begin
            word.word_data <= {din, part_buf};  // closing beat lands in the top slice
            word.word_idx  <= idx_cnt;
        end
    end

endmodule

// File: source/dram_write_arbiter.sv
module dram_write_arbiter (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             en_write,
    dram_word_if.consumer                    ch_a,
    dram_word_if.consumer                    ch_b,
    output logic [dram_pkg::DRAM_ADDR_W-1:0] dram_addr,
    output logic [dram_pkg::DRAM_DATA_W-1:0] dram_data,
    output logic                             cmd_valid,
    output logic                             rwn
);

    // one pending slot per channel
    logic                             a_full;
    logic                             b_full;
    logic [dram_pkg::DRAM_DATA_W-1:0] a_data;
    logic [dram_pkg::DRAM_DATA_W-1:0] b_data;
    logic [dram_pkg::WORD_IDX_W-1:0]  a_idx;
    logic [dram_pkg::WORD_IDX_W-1:0]  b_idx;

    logic issue_a;  // slot a leaves this cycle
    logic issue_b;  // slot b leaves this cycle
    logic issue;

    // fixed priority with a always winning
    assign issue_a = a_full;
    assign issue_b = b_full && !a_full;
    assign issue   = issue_a || issue_b;

    // slot occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            a_full <= 1'b0;
            b_full <= 1'b0;
        end else begin
            // a new word may arrive in the cycle its slot drains
            if (ch_a.word_valid) begin
                a_full <= 1'b1;
            end else if (issue_a) begin
                a_full <= 1'b0;
            end

            if (ch_b.word_valid) begin
                b_full <= 1'b1;
            end else if (issue_b) begin
                b_full <= 1'b0;
            end
        end
    end

    // slot payload
    always_ff @(posedge clk) begin
        if (ch_a.word_valid) begin
            a_data <= ch_a.word_data;
            a_idx  <= ch_a.word_idx;
        end
        if (ch_b.word_valid) begin
            b_data <= ch_b.word_data;
            b_idx  <= ch_b.word_idx;
        end
    end

    // command word straight out of the slot being issued
    always_comb begin
        if (issue_a) begin
            dram_addr = {dram_pkg::CH_A_SEL, a_idx};
            dram_data = a_data;
        end else begin
            dram_addr = {dram_pkg::CH_B_SEL, b_idx};  // also the idle value
            dram_data = b_data;
        end
    end

    // with writes disabled the slot still drains and its index is lost
    assign cmd_valid = issue && en_write;

    // 1 means read so it is high whenever writes are off
    always_ff @(posedge clk) begin
        if (rst) begin
            rwn <= 1'b1;
        end else begin
            rwn <= ~en_write;
        end
    end

endmodule

// File: source/dual_capture_top.sv
module dual_capture_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             en_write,
    input  logic [dram_pkg::CH_A_W-1:0]      a_din,
    input  logic                             a_valid,
    input  logic [dram_pkg::CH_B_W-1:0]      b_din,
    input  logic                             b_valid,
    output logic [dram_pkg::DRAM_ADDR_W-1:0] dram_addr,
    output logic [dram_pkg::DRAM_DATA_W-1:0] dram_data,
    output logic                             cmd_valid,
    output logic                             rwn
);

    // finished words from each packer
    dram_word_if word_a (
        .clk (clk)
    );

    dram_word_if word_b (
        .clk (clk)
    );

    // channel a with 32 bit beats
    sample_packer #(
        .DIN_W (dram_pkg::CH_A_W)
    ) u_pack_a (
        .clk       (clk),
        .rst       (rst),
        .din       (a_din),
        .din_valid (a_valid),
        .word      (word_a.producer)
    );

    // channel b with 16 bit beats
    sample_packer #(
        .DIN_W (dram_pkg::CH_B_W)
    ) u_pack_b (
        .clk       (clk),
        .rst       (rst),
        .din       (b_din),
        .din_valid (b_valid),
        .word      (word_b.producer)
    );

    // merge into the single write port
    dram_write_arbiter u_arb (
        .clk       (clk),
        .rst       (rst),
        .en_write  (en_write),
        .ch_a      (word_a.consumer),
        .ch_b      (word_b.consumer),
        .dram_addr (dram_addr),
        .dram_data (dram_data),
        .cmd_valid (cmd_valid),
        .rwn       (rwn)
    );

endmodule

// File: tb/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD = 8  // time units per clock cycle
) (
    output logic clk
);

    // free running clock that starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

// File: tb/tb_dual_capture.sv
module tb_dual_capture;

    localparam int CLK_PERIOD = 8;
    localparam int DW         = dram_pkg::DRAM_DATA_W;
    localparam int AW         = dram_pkg::DRAM_ADDR_W;
    localparam int IW         = dram_pkg::WORD_IDX_W;
    localparam int A_W        = dram_pkg::CH_A_W;
    localparam int B_W        = dram_pkg::CH_B_W;
    localparam int A_BEATS    = DW / A_W;  // 9
    localparam int B_BEATS    = DW / B_W;  // 18

    localparam logic [31:0] LFSR_SEED = 32'h13d9_a9c5;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    // beats driven by each test
    localparam int T1_BEATS    = 3 * A_BEATS;
    localparam int T2_BEATS    = 2 * B_BEATS;
    localparam int T3_BEATS    = A_BEATS + B_BEATS;
    localparam int T4_BEATS    = 2 * A_BEATS;
    localparam int T5_BEATS    = 4 + 7 + A_BEATS + B_BEATS;
    localparam int TOTAL_BEATS = T1_BEATS + T2_BEATS + T3_BEATS + T4_BEATS + T5_BEATS;
    localparam int MARGIN      = 250 * CLK_PERIOD;  // idle cycles, resets, drain waits
    localparam int WATCHDOG    = TOTAL_BEATS * CLK_PERIOD + MARGIN;
    localparam int DRAIN_LIMIT = 20;  // cycles allowed for pending commands

    logic          clk;
    logic          rst;
    logic          en_write;
    logic [A_W-1:0] a_din;
    logic          a_valid;
    logic [B_W-1:0] b_din;
    logic          b_valid;
    logic [AW-1:0] dram_addr;
    logic [DW-1:0] dram_data;
    logic          cmd_valid;
    logic          rwn;

    int          errors = 0;
    int          cyc = 0;      // posedges seen so far
    logic [31:0] lfsr = LFSR_SEED;

    // reference model state
    logic [DW-1:0] acc_a;
    logic [DW-1:0] acc_b;
    int            cnt_a = 0;
    int            cnt_b = 0;
    logic [IW-1:0] idx_a = '0;
    logic [IW-1:0] idx_b = '0;
    int            last_issue = 0;  // cycle of the latest command slot
    logic          drop_words = 1'b0;

    // expected commands, in issue order
    logic [AW-1:0] exp_addr[$];
    logic [DW-1:0] exp_data[$];
    int            exp_cyc[$];

    tb_clock_gen #(
        .PERIOD (CLK_PERIOD)
    ) u_clk (
        .clk (clk)
    );

    dual_capture_top i_dual_capture_top (
        .clk       (clk),
        .rst       (rst),
        .en_write  (en_write),
        .a_din     (a_din),
        .a_valid   (a_valid),
        .b_din     (b_din),
        .b_valid   (b_valid),
        .dram_addr (dram_addr),
        .dram_data (dram_data),
        .cmd_valid (cmd_valid),
        .rwn       (rwn)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        out_bit;
        int          i;
        val = '0;
        for (i = 0; i < n; i++) begin
            out_bit = lfsr[0];
            lfsr    = lfsr >> 1;
            if (out_bit) begin
                lfsr = lfsr ^ LFSR_TAPS;
            end
            val = {val[30:0], out_bit};
        end
        return val;
    endfunction

    task automatic check_value(input string name, input logic [DW-1:0] got,
                               input logic [DW-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // a finished word takes the next free command slot 2 cycles after its last beat
    task automatic word_done(input logic sel, input logic [IW-1:0] idx,
                             input logic [DW-1:0] data);
        int c;
        c = cyc + 2;
        if (c <= last_issue) begin
            c = last_issue + 1;  // other channel already owns that cycle
        end
        last_issue = c;
        if (!drop_words) begin
            exp_addr.push_back({sel, idx});
            exp_data.push_back(data);
            exp_cyc.push_back(c);
        end
    endtask

    task automatic model_beat_a(input logic [A_W-1:0] d);
        acc_a[cnt_a*A_W +: A_W] = d;  // first beat lowest
        cnt_a++;
        if (cnt_a == A_BEATS) begin
            word_done(dram_pkg::CH_A_SEL, idx_a, acc_a);
            idx_a = idx_a + 1'b1;
            cnt_a = 0;
        end
    endtask

    task automatic model_beat_b(input logic [B_W-1:0] d);
        acc_b[cnt_b*B_W +: B_W] = d;
        cnt_b++;
        if (cnt_b == B_BEATS) begin
            word_done(dram_pkg::CH_B_SEL, idx_b, acc_b);
            idx_b = idx_b + 1'b1;
            cnt_b = 0;
        end
    endtask

    // one clock of stimulus with channel a modelled first so it wins a tie
    task automatic drive(input logic av, input logic [A_W-1:0] ad,
                         input logic bv, input logic [B_W-1:0] bd);
        @(negedge clk);
        a_valid = av;
        a_din   = ad;
        b_valid = bv;
        b_din   = bd;
        if (av) begin
            model_beat_a(ad);
        end
        if (bv) begin
            model_beat_b(bd);
        end
    endtask

    task automatic idle(input int n);
        logic [31:0] r;
        repeat (n) begin
            r = rand_bits(32);
            drive(1'b0, r, 1'b0, r[B_W-1:0]);  // junk on the data lines
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst     = 1'b1;
        a_valid = 1'b0;
        b_valid = 1'b0;
        repeat (3) @(negedge clk);
        rst   = 1'b0;
        acc_a = '0;
        acc_b = '0;
        cnt_a = 0;
        cnt_b = 0;
        idx_a = '0;
        idx_b = '0;
    endtask

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        while (exp_addr.size() != 0 && n < DRAIN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (exp_addr.size() != 0) begin
            errors++;
            $display("%0d commands missing %s, cmd_valid never came for them",
                     exp_addr.size(), what);
            exp_addr.delete();
            exp_data.delete();
            exp_cyc.delete();
        end
    endtask

    task automatic channel_a_words();
        logic [31:0] r;
        idle(1);
        check_value("rwn", DW'(rwn), DW'(1'b0));  // writes on since reset ended
        repeat (T1_BEATS) begin
            r = rand_bits(A_W);
            drive(1'b1, r, 1'b0, '0);
        end
        idle(2);
        wait_drained("after channel a words");
    endtask

    task automatic channel_b_words();
        logic [31:0] r;
        repeat (T2_BEATS) begin
            r = rand_bits(B_W);
            drive(1'b0, '0, 1'b1, r[B_W-1:0]);
        end
        idle(2);
        wait_drained("after channel b words");
    endtask

    // both last beats land in cycle 19 with gaps in each stream
    task automatic simultaneous_finish();
        logic [31:0] ra;
        logic [31:0] rb;
        logic        av;
        logic        bv;
        int          i;
        for (i = 0; i < 20; i++) begin
            ra = rand_bits(A_W);
            rb = rand_bits(B_W);
            av = (i % 2 == 1) && (i >= 3);
            bv = (i != 5) && (i != 11);
            drive(av, ra, bv, rb[B_W-1:0]);
        end
        idle(3);
        wait_drained("after the simultaneous words");
    endtask

    task automatic writes_disabled();
        logic [31:0] r;
        repeat (A_BEATS - 1) begin
            r = rand_bits(A_W);
            drive(1'b1, r, 1'b0, '0);
        end
        r = rand_bits(A_W);
        drop_words = 1'b1;
        drive(1'b1, r, 1'b0, '0);
        en_write   = 1'b0;     // low across the issue cycle
        drop_words = 1'b0;
        idle(4);
        check_value("rwn", DW'(rwn), DW'(1'b1));
        en_write = 1'b1;
        idle(2);
        check_value("rwn", DW'(rwn), DW'(1'b0));
        repeat (A_BEATS) begin  // next index after the lost one
            r = rand_bits(A_W);
            drive(1'b1, r, 1'b0, '0);
        end
        idle(2);
        wait_drained("after writes came back");
    endtask

    task automatic reset_mid_word();
        logic [31:0] ra;
        logic [31:0] rb;
        int          i;
        for (i = 0; i < 7; i++) begin
            ra = rand_bits(A_W);
            rb = rand_bits(B_W);
            drive(i < 4, ra, 1'b1, rb[B_W-1:0]);
        end
        apply_reset();  // partial words in both packers are gone
        repeat (A_BEATS) begin
            ra = rand_bits(A_W);
            drive(1'b1, ra, 1'b0, '0);
        end
        idle(1);
        repeat (B_BEATS) begin
            rb = rand_bits(B_W);
            drive(1'b0, '0, 1'b1, rb[B_W-1:0]);
        end
        idle(2);
        wait_drained("after the mid word reset");
    endtask

    // compare every command against the model late in the cycle
    always begin : monitor
        logic [AW-1:0] e_addr;
        logic [DW-1:0] e_data;
        int            e_cyc;
        @(posedge clk);
        #(CLK_PERIOD * 3 / 4);
        if (cmd_valid === 1'b1) begin
            if (exp_addr.size() == 0) begin
                errors++;
                $display("unexpected cmd_valid at %0t, no command was due", $time);
            end else begin
                e_addr = exp_addr.pop_front();
                e_data = exp_data.pop_front();
                e_cyc  = exp_cyc.pop_front();
                check_value("dram_addr", DW'(dram_addr), DW'(e_addr));
                check_value("dram_data", dram_data, e_data);
                check_value("cmd_valid cycle", DW'(cyc), DW'(e_cyc));
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG);
        $display("timeout, the tests did not finish within %0d time units, %0d errors",
                 WATCHDOG, errors);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        rst      = 1'b1;
        en_write = 1'b1;
        a_din    = '0;
        a_valid  = 1'b0;
        b_din    = '0;
        b_valid  = 1'b0;
        acc_a    = '0;
        acc_b    = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        channel_a_words();
        channel_b_words();
        simultaneous_finish();
        writes_disabled();
        reset_mid_word();

        idle(4);
        wait_drained("at the end");
        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
source/dram_pkg.sv
source/dram_word_if.sv
source/sample_packer.sv
source/dram_write_arbiter.sv
source/dual_capture_top.sv
tb/tb_clock_gen.sv
tb/tb_dual_capture.sv

// File: run.sh
#!/bin/sh
# compile and run the dual capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module tb_dual_capture \
    -f tb.f \
    -Mdir obj_dir \
    -o sim_dual_capture
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

sim_out=$(./obj_dir/sim_dual_capture)
status=$?
printf '%s\n' "$sim_out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the verdict is a line of its own in the output
if printf '%s\n' "$sim_out" | grep -qx 'TEST PASS'; then
    exit 0
fi

echo "pass message not found in the simulation output"
exit 1
